// File: common/arcade_consts.svh
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// ROM store word address bits, 16K words = 32 KB
`define ARC_ROM_AW 14

// Host byte address width on the ioctl bus
`define ARC_IOCTL_AW 25

// Bits per VGA colour channel
`define ARC_VGA_W 6

`endif

// File: common/arcade_pkg.sv
`include "arcade_consts.svh"

package arcade_pkg;

	typedef struct packed {
		logic        spare_31;
		logic        service;     // 30
		logic        freeze;      // 29
		logic [28:10] spare_mid;
		logic [1:0]  lives;       // 9:8
		logic [7:1]  spare_lo;
		logic        reset;       // 0
	} druaga_view_t;

	typedef struct packed {
		logic        spare_31;
		logic        service;
		logic        freeze;
		logic [28:19] spare_mid;
		logic [1:0]  lives;       // 18:17
		logic [2:0]  extend;      // 16:14
		logic        demo_snd;    // 13
		logic [2:0]  rank;        // 12:10
		logic [9:7]  spare_lo;
		logic        round_sel;   // 6
		logic [5:1]  spare_bot;
		logic        reset;
	} mappy_view_t;

	typedef struct packed {
		logic        spare_31;
		logic        service;
		logic        freeze;
		logic [28:23] spare_mid;
		logic        level_sel;   // 22
		logic [1:0]  extend;      // 21:20
		logic        lives;       // 19
		logic [18:1] spare_lo;
		logic        reset;
	} digdug2_view_t;

	typedef struct packed {
		logic        spare_31;
		logic        service;
		logic        freeze;
		logic        spare_28;
		logic        demo_snd;    // 27
		logic [1:0]  extend;      // 26:25
		logic        rank;        // 24
		logic        lives;       // 23
		logic [22:1] spare_lo;
		logic        reset;
	} motos_view_t;

	// Host status word, one DIP layout per game family
	typedef union packed {
		logic [31:0]   raw;
		druaga_view_t  druaga;
		mappy_view_t   mappy;
		digdug2_view_t digdug2;
		motos_view_t   motos;
	} status_word_u;

	typedef enum logic [2:0] {
		GM_DRUAGA       = 3'd0,
		GM_DRUAGA_ALT   = 3'd1,
		GM_MAPPY        = 3'd2,
		GM_DIGDUG2      = 3'd3,
		GM_MOTOS        = 3'd4,
		GM_SUPER_PACMAN = 3'd5,
		GM_GROBDA       = 3'd6,
		GM_PHOZON       = 3'd7
	} game_model_t;

	typedef struct packed {
		logic                     download;
		logic                     wr;
		logic [`ARC_IOCTL_AW-1:0] addr;
		logic [7:0]               data;
	} ioctl_bus_t;

	typedef struct packed {
		logic p1_up;
		logic p1_down;
		logic p1_left;
		logic p1_right;
		logic p1_fire_a;
		logic p1_fire_b;
		logic p2_up;
		logic p2_down;
		logic p2_left;
		logic p2_right;
		logic p2_fire_a;
		logic p2_fire_b;
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
	} controls_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       hblank;
		logic       vblank;
		logic       hsync;
		logic       vsync;
	} game_pixel_t;

	typedef struct packed {
		logic [`ARC_VGA_W-1:0] r;
		logic [`ARC_VGA_W-1:0] g;
		logic [`ARC_VGA_W-1:0] b;
		logic                  hs;
		logic                  vs;
	} vga_out_t;

	typedef struct packed {
		logic [7:0] dsw0;
		logic [7:0] dsw1;
		logic [7:0] dsw2;
	} dip_set_t;

	typedef struct packed {
		logic [5:0] inp0;
		logic [5:0] inp1;
		logic [2:0] inp2;
	} inp_set_t;

endpackage

// File: design/arcade_glue_top.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module arcade_glue_top
	import arcade_pkg::*;
(
	input  logic                   clock_48,
	input  logic                   rst,
	input  status_word_u           status,
	input  logic [1:0]             buttons,
	input  game_model_t            model,
	input  ioctl_bus_t             ioctl,
	input  controls_t              controls,
	input  logic [`ARC_ROM_AW:0]   rom_addr,
	input  game_pixel_t            game_pixel,
	output logic [7:0]             rom_data,
	output dip_set_t               dips,
	output inp_set_t               inps,
	output logic                   game_reset,
	output logic                   led,
	output vga_out_t               vga
);

	logic                   wr_en;
	logic [`ARC_ROM_AW-1:0] wr_addr;
	logic [1:0]             wr_lanes;
	logic [15:0]            wr_data;

	assign led = ~ioctl.download; // Lit when idle

	rom_loader u_rom_loader (
		.clock_48 (clock_48),
		.rst      (rst),
		.ioctl    (ioctl),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_lanes (wr_lanes),
		.wr_data  (wr_data)
	);

	rom_store u_rom_store (
		.clock_48 (clock_48),
		.download (ioctl.download),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_lanes (wr_lanes),
		.wr_data  (wr_data),
		.rom_addr (rom_addr),
		.rom_data (rom_data)
	);

	// Button 1 doubles as a manual reset
	reset_sequencer u_reset_sequencer (
		.clock_48       (clock_48),
		.rst            (rst),
		.download       (ioctl.download),
		.status_reset   (status.raw[0]),
		.service_button (buttons[1]),
		.game_reset     (game_reset),
		.rom_loaded     ()
	);

	panel_mapper u_panel_mapper (
		.status   (status),
		.model    (model),
		.controls (controls),
		.dips     (dips),
		.inps     (inps)
	);

	video_blanker u_video_blanker (
		.clock_48   (clock_48),
		.rst        (rst),
		.game_pixel (game_pixel),
		.vga        (vga)
	);

endmodule

// File: design/panel_mapper.sv
`timescale 1ns/1ps

module panel_mapper
	import arcade_pkg::*;
(
	input  status_word_u status,
	input  game_model_t  model,
	input  controls_t    controls,
	output dip_set_t     dips,
	output inp_set_t     inps
);

	localparam logic CABINET = 1'b0; // Upright only

	always_comb begin
		inps.inp0 = {controls.p1_fire_b, controls.p1_fire_a, controls.p1_left,
			controls.p1_down, controls.p1_right, controls.p1_up};
		inps.inp1 = {controls.p2_fire_b, controls.p2_fire_a, controls.p2_left,
			controls.p2_down, controls.p2_right, controls.p2_up};
		inps.inp2 = {controls.coin1 | controls.coin2, controls.start2, controls.start1};
	end

	always_comb begin
		dips = '0;

		case (model)
			GM_DRUAGA, GM_DRUAGA_ALT: begin
				dips.dsw0 = {2'b00, status.druaga.lives, 4'b0000};
				dips.dsw1 = {CABINET, 6'b000000, status.druaga.freeze};
				dips.dsw2 = {dips.dsw1[3:0], status.druaga.service, 3'b000};
			end
			GM_MAPPY: begin
				dips.dsw0 = {status.mappy.freeze, status.mappy.round_sel,
					status.mappy.demo_snd, 2'b00, status.mappy.rank};
				dips.dsw1 = {status.mappy.lives, status.mappy.extend, 3'b000};
				dips.dsw2 = {2{status.mappy.service, CABINET, 2'b00}};
			end
			GM_DIGDUG2: begin
				dips.dsw0 = {2'b00, status.digdug2.lives, 5'b00000};
				dips.dsw1 = {CABINET, 3'b000, status.digdug2.freeze,
					status.digdug2.level_sel, status.digdug2.extend};
				// Same fold of dsw1 as druaga
				dips.dsw2 = {dips.dsw1[3:0], status.digdug2.service, 3'b000};
			end
			GM_MOTOS: begin
				dips.dsw0 = {status.motos.demo_snd, status.motos.extend,
					status.motos.rank, status.motos.lives, 3'b000};
				dips.dsw1 = {status.motos.service, CABINET, 6'b000000};
				dips.dsw2 = 8'h00;
			end
			default: begin
				dips = '0; // Pacman, grobda, phozon have no DIP mapping
			end
		endcase
	end

endmodule

// File: design/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
	input  logic clock_48,
	input  logic rst,
	input  logic download,
	input  logic status_reset,
	input  logic service_button,
	output logic game_reset,
	output logic rom_loaded
);

	logic download_d;

	always_ff @(posedge clock_48) begin
		if (rst) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			game_reset <= 1'b1;
		end else begin
			download_d <= download;
			if (download_d && !download)
				rom_loaded <= 1'b1; // Sticky once a download ends
			// Uses last cycle's rom_loaded
			game_reset <= status_reset | service_button | download | ~rom_loaded;
		end
	end

endmodule

// File: design/video_blanker.sv
`timescale 1ns/1ps

module video_blanker
	import arcade_pkg::*;
(
	input  logic        clock_48,
	input  logic        rst,
	input  game_pixel_t game_pixel,
	output vga_out_t    vga
);

	logic       blank;
	logic [2:0] blue3;

	assign blank = game_pixel.hblank | game_pixel.vblank;
	assign blue3 = {game_pixel.b, game_pixel.b[1]}; // 2 to 3 bits

	always_ff @(posedge clock_48) begin
		if (rst) begin
			vga <= '0;
		end else begin
			if (blank) begin
				vga.r <= '0;
				vga.g <= '0;
				vga.b <= '0;
			end else begin
				// Repeat each 3-bit channel to fill 6 bits
				vga.r <= {2{game_pixel.r}};
				vga.g <= {2{game_pixel.g}};
				vga.b <= {2{blue3}};
			end
			vga.hs <= game_pixel.hsync;
			vga.vs <= game_pixel.vsync;
		end
	end

endmodule

// File: rom_loader/rom_loader.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module rom_loader
	import arcade_pkg::*;
(
	input  logic                   clock_48,
	input  logic                   rst,
	input  ioctl_bus_t             ioctl,
	output logic                   wr_en,
	output logic [`ARC_ROM_AW-1:0] wr_addr,
	output logic [1:0]             wr_lanes,
	output logic [15:0]            wr_data
);

	logic wr_prev;
	logic in_range;
	logic wr_rise;

	// Anything above the 32 KB store is ignored
	assign in_range = ~|ioctl.addr[`ARC_IOCTL_AW-1:`ARC_ROM_AW+1];
	assign wr_rise  = ioctl.download & ioctl.wr & ~wr_prev & in_range;

	always_ff @(posedge clock_48) begin
		if (rst) begin
			wr_prev <= 1'b0;
			wr_en   <= 1'b0;
		end else begin
			wr_prev <= ioctl.wr;
			wr_en   <= wr_rise; // One pulse per strobe
		end
	end

	always_ff @(posedge clock_48) begin
		if (wr_rise) begin
			wr_addr  <= ioctl.addr[`ARC_ROM_AW:1];
			wr_lanes <= {ioctl.addr[0], ~ioctl.addr[0]}; // Odd byte to upper lane
			wr_data  <= {2{ioctl.data}};
		end
	end

endmodule

// File: rom_loader/rom_store.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module rom_store (
	input  logic                   clock_48,
	input  logic                   download,
	input  logic                   wr_en,
	input  logic [`ARC_ROM_AW-1:0] wr_addr,
	input  logic [1:0]             wr_lanes,
	input  logic [15:0]            wr_data,
	input  logic [`ARC_ROM_AW:0]   rom_addr,
	output logic [7:0]             rom_data
);

	localparam int DEPTH = 2 ** `ARC_ROM_AW;

	logic [15:0] mem [0:DEPTH-1];

	logic [`ARC_ROM_AW-1:0] rd_addr;
	logic [15:0]            rd_word;
	logic                   hi_sel;

	// Game reads are parked on the top word while loading
	assign rd_addr = download ? '1 : rom_addr[`ARC_ROM_AW:1];

	always_ff @(posedge clock_48) begin
		if (wr_en) begin
			if (wr_lanes[0])
				mem[wr_addr][7:0] <= wr_data[7:0];
			if (wr_lanes[1])
				mem[wr_addr][15:8] <= wr_data[15:8];
		end
	end

	always_ff @(posedge clock_48) begin
		rd_word <= mem[rd_addr];
		hi_sel  <= rom_addr[0]; // Aligned with rd_word
	end

	assign rom_data = hi_sel ? rd_word[15:8] : rd_word[7:0];

endmodule

// File: tb.f
+incdir+common
common/arcade_pkg.sv
rom_loader/rom_loader.sv
rom_loader/rom_store.sv
design/reset_sequencer.sv
design/panel_mapper.sv
design/video_blanker.sv
design/arcade_glue_top.sv
verification/arcade_glue_tb.sv

// File: verification/arcade_glue_tb.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module arcade_glue_tb
	import arcade_pkg::*;
;

	localparam int N_BYTES = 512;
	localparam int N_DIP   = 64;
	localparam int N_INP   = 200;
	localparam int N_PIX   = 500;
	localparam int ROM_BYTES = 2 ** (`ARC_ROM_AW + 1);
	// Worst case per byte is one setup, five strobe and one gap cycle
	localparam int MAX_CYCLES = 8 + N_BYTES * 7 + 8 + N_BYTES + 4 + 8 * N_DIP
		+ N_INP + 24 + N_PIX + 4 + 256;

	logic                 clock_48;
	logic                 rst;
	status_word_u         status;
	logic [1:0]           buttons;
	game_model_t          model;
	ioctl_bus_t           ioctl;
	controls_t            controls;
	logic [`ARC_ROM_AW:0] rom_addr;
	game_pixel_t          game_pixel;
	logic [7:0]           rom_data;
	dip_set_t             dips;
	inp_set_t             inps;
	logic                 game_reset;
	logic                 led;
	vga_out_t             vga;

	integer      seed = 32'h4754ec58;
	int          errors = 0;
	int          n_compared = 0;
	logic [7:0]  rom_model [0:ROM_BYTES-1];
	bit          written [0:ROM_BYTES-1];
	logic        rd_active;
	bit          rom_ready = 1'b0;

	// Compare process history, one clock back
	game_pixel_t          prev_pixel = '0;
	logic                 prev_rst = 1'b1;
	logic                 prev_dl = 1'b1;
	logic                 prev_src = 1'b1;
	logic                 prev_rd = 1'b0;
	logic [`ARC_ROM_AW:0] prev_rd_addr = '0;

	arcade_glue_top dut (
		.clock_48   (clock_48),
		.rst        (rst),
		.status     (status),
		.buttons    (buttons),
		.model      (model),
		.ioctl      (ioctl),
		.controls   (controls),
		.rom_addr   (rom_addr),
		.game_pixel (game_pixel),
		.rom_data   (rom_data),
		.dips       (dips),
		.inps       (inps),
		.game_reset (game_reset),
		.led        (led),
		.vga        (vga)
	);

	initial begin
		clock_48 = 1'b0;
		forever #50 clock_48 = ~clock_48;
	end

	function automatic dip_set_t ref_dips(input logic [31:0] s, input logic [2:0] m);
		dip_set_t d;
		d = '0;
		case (m)
			3'd0, 3'd1: begin
				d.dsw0 = {2'b00, s[9:8], 4'b0000};
				d.dsw1 = {1'b0, 6'b000000, s[29]};
				d.dsw2 = {d.dsw1[3:0], s[30], 3'b000};
			end
			3'd2: begin
				d.dsw0 = {s[29], s[6], s[13], 2'b00, s[12:10]};
				d.dsw1 = {s[18:17], s[16:14], 3'b000};
				d.dsw2 = {s[30], 3'b000, s[30], 3'b000};
			end
			3'd3: begin
				d.dsw0 = {2'b00, s[19], 5'b00000};
				d.dsw1 = {4'b0000, s[29], s[22], s[21:20]};
				d.dsw2 = {d.dsw1[3:0], s[30], 3'b000};
			end
			3'd4: begin
				d.dsw0 = {s[27], s[26:25], s[24], s[23], 3'b000};
				d.dsw1 = {s[30], 7'b0000000};
			end
			default: d = '0; // No DIPs on the later games
		endcase
		return d;
	endfunction

	function automatic inp_set_t ref_inps(input controls_t c);
		inp_set_t p;
		p.inp0 = {c.p1_fire_b, c.p1_fire_a, c.p1_left, c.p1_down, c.p1_right, c.p1_up};
		p.inp1 = {c.p2_fire_b, c.p2_fire_a, c.p2_left, c.p2_down, c.p2_right, c.p2_up};
		p.inp2 = {c.coin1 | c.coin2, c.start2, c.start1};
		return p;
	endfunction

	function automatic vga_out_t ref_vga(input game_pixel_t p);
		vga_out_t   v;
		logic [2:0] b3;
		b3 = {p.b, p.b[1]};
		v.hs = p.hsync;
		v.vs = p.vsync;
		if (p.hblank || p.vblank) begin
			v.r = '0;
			v.g = '0;
			v.b = '0;
		end else begin
			v.r = {p.r, p.r};
			v.g = {p.g, p.g};
			v.b = {b3, b3};
		end
		return v;
	endfunction

	function automatic logic [7:0] expected_rom_byte(input logic [`ARC_ROM_AW:0] a);
		return rom_model[a];
	endfunction

	task automatic report_mismatch(input string test, input logic [31:0] exp,
		input logic [31:0] act);
		$display("Fail %s: expected %h, actual %h", test, exp, act);
		errors++;
	endtask

	always @(negedge clock_48) begin
		if (!rst) begin
			n_compared++;
			if (led !== ~ioctl.download)
				report_mismatch("led", ~ioctl.download, led);
			if (dips !== ref_dips(status.raw, model))
				report_mismatch("dips", ref_dips(status.raw, model), dips);
			if (inps !== ref_inps(controls))
				report_mismatch("inps", ref_inps(controls), inps);
			if (prev_dl && game_reset !== 1'b1)
				report_mismatch("reset during download", 1, game_reset);
			if (rom_ready && game_reset !== prev_src)
				report_mismatch("game_reset", prev_src, game_reset);
			if (!prev_rst && vga !== ref_vga(prev_pixel))
				report_mismatch("vga", ref_vga(prev_pixel), vga);
			if (prev_rd && rom_data !== expected_rom_byte(prev_rd_addr))
				report_mismatch("rom readback", expected_rom_byte(prev_rd_addr), rom_data);
		end
		prev_rst     = rst;
		prev_dl      = ioctl.download;
		prev_src     = status.raw[0] | buttons[1] | ioctl.download;
		prev_pixel   = game_pixel;
		prev_rd      = rd_active;
		prev_rd_addr = rom_addr;
	end

	task automatic check_reset_state();
		if (game_reset !== 1'b1)
			report_mismatch("reset game_reset", 1, game_reset);
		if (led !== 1'b0)
			report_mismatch("reset led", 0, led);
		if (vga !== '0)
			report_mismatch("reset vga", 0, vga);
	endtask

	task automatic load_rom();
		logic [31:0]              rnd;
		logic [`ARC_IOCTL_AW-1:0] a;
		logic [`ARC_ROM_AW:0]     last_a;
		int                       hold;
		last_a = '0;
		for (int i = 0; i < N_BYTES; i++) begin
			rnd  = $random(seed);
			a    = '0;
			a[`ARC_ROM_AW:0] = rnd[`ARC_ROM_AW:0];
			if (rnd[31:29] == 3'd0) begin
				a[`ARC_ROM_AW:0] = last_a; // Aliases a byte that is read back
				a[`ARC_IOCTL_AW-1:`ARC_ROM_AW+1] = {rnd[28:20], 1'b1}; // Beyond the store
			end
			hold = 2 + ($random(seed) & 3);
			@(posedge clock_48);
			ioctl.addr <= a;
			ioctl.data <= rnd[27:20];
			ioctl.wr   <= 1'b1;
			if (a[`ARC_IOCTL_AW-1:`ARC_ROM_AW+1] == '0) begin
				rom_model[a[`ARC_ROM_AW:0]] = rnd[27:20];
				written[a[`ARC_ROM_AW:0]]   = 1'b1;
				last_a = a[`ARC_ROM_AW:0];
			end
			@(posedge clock_48);
			ioctl.data <= ~rnd[27:20]; // Only the first strobe cycle counts
			repeat (hold - 1) @(posedge clock_48);
			ioctl.wr <= 1'b0;
			repeat ($random(seed) & 1) @(posedge clock_48);
		end
		repeat (4) @(posedge clock_48);
		ioctl.download <= 1'b0;
		@(negedge clock_48);
		@(negedge clock_48);
		if (game_reset !== 1'b1)
			report_mismatch("reset release early", 1, game_reset);
		@(negedge clock_48);
		if (game_reset !== 1'b0)
			report_mismatch("reset release", 0, game_reset);
		rom_ready = 1'b1;
	endtask

	task automatic read_rom();
		for (int a = 0; a < ROM_BYTES; a++) begin
			if (written[a]) begin
				@(posedge clock_48);
				rom_addr  <= a[`ARC_ROM_AW:0];
				rd_active <= 1'b1;
			end
		end
		@(posedge clock_48);
		rd_active <= 1'b0;
	endtask

	task automatic pulse_reset_source(input bit use_button);
		@(posedge clock_48);
		if (use_button)
			buttons <= 2'b10;
		else
			status.raw[0] <= 1'b1;
		@(negedge clock_48);
		if (game_reset !== 1'b0)
			report_mismatch("reset source same cycle", 0, game_reset);
		@(negedge clock_48);
		if (game_reset !== 1'b1)
			report_mismatch("reset source", 1, game_reset);
		@(posedge clock_48);
		buttons <= 2'b00;
		status  <= '0;
		repeat (2) @(posedge clock_48);
	endtask

	initial begin
		logic [31:0] rnd;
		rst        = 1'b1;
		status     = '0;
		buttons    = 2'b00;
		model      = GM_DRUAGA;
		ioctl      = '0;
		ioctl.download = 1'b1; // Host starts loading at power up
		controls   = '0;
		rom_addr   = '0;
		game_pixel = 12'hff3; // Lit pixel with both syncs high
		rd_active  = 1'b0;

		repeat (7) @(posedge clock_48);
		@(negedge clock_48);
		check_reset_state();
		@(posedge clock_48);
		rst <= 1'b0;

		load_rom();
		read_rom();

		for (int m = 0; m < 8; m++) begin
			for (int i = 0; i < N_DIP; i++) begin
				@(posedge clock_48);
				status.raw <= $random(seed);
				model      <= game_model_t'(m[2:0]);
			end
		end

		@(posedge clock_48);
		status <= '0;
		for (int i = 0; i < N_INP; i++) begin
			rnd = $random(seed);
			@(posedge clock_48);
			controls <= rnd[15:0];
		end
		repeat (2) @(posedge clock_48);
		pulse_reset_source(1'b0);
		pulse_reset_source(1'b1);

		for (int i = 0; i < N_PIX; i++) begin
			rnd = $random(seed);
			@(posedge clock_48);
			game_pixel        <= rnd[11:0];
			game_pixel.hblank <= (rnd[15:13] == 3'd0);
			game_pixel.vblank <= (rnd[18:16] == 3'd0);
		end
		repeat (3) @(posedge clock_48);

		$display("Errors: %0d, compared cycles: %0d", errors, n_compared);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial begin
		repeat (MAX_CYCLES) @(posedge clock_48);
		$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
		$display("Errors: %0d, compared cycles: %0d", errors, n_compared);
		$display("Testbench failed");
		$finish;
	end

endmodule
